/* src.f */
+incdir+logic
logic/disp_pkg.sv
logic/draw_pkg.sv
logic/display_timing.sv
logic/draw_sequencer.sv
logic/line_engine.sv
logic/framebuffer.sv
logic/line_display_top.sv
verification/tb_line_display.sv

/* verification/tb_line_display.sv */
// testbench for the line drawing display top
// random lines against a Bresenham and framebuffer model plus raster and busy checks

`timescale 1ns/1ps

`include "gfx_defines.svh"

module tb_line_display;

    localparam int NUM_LINES    = 12;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int MAX_CYCLES   = (NUM_LINES + 4) * FRAME_CYCLES + 10000;

    logic             clk_pix;
    logic             rst_n;
    logic             req;
    draw_pkg::coord_t x0, y0, x1, y1;
    draw_pkg::cidx_t  cidx;
    logic             busy, hsync, vsync, de;
    draw_pkg::chan_t  red, green, blue;

    integer seed;
    int     cycles = 0;
    int     rgb_errs = 0, sync_errs = 0, busy_errs = 0;
    int     msx, msy;                   // model position the outputs refer to
    bit     synced = 0;
    logic   vsync_prev = 1'b1;
    int     frame_count = 0;            // frame starts seen by the monitor

    draw_pkg::cidx_t pending [`FB_WIDTH][`FB_HEIGHT];   // all lines issued so far
    draw_pkg::cidx_t shown [`FB_WIDTH][`FB_HEIGHT];     // picture being scanned

    line_display_top i_line_display_top (
        .clk_pix (clk_pix), .rst_n (rst_n), .req (req),
        .x0 (x0), .y0 (y0), .x1 (x1), .y1 (y1), .cidx (cidx),
        .busy (busy), .hsync (hsync), .vsync (vsync), .de (de),
        .red (red), .green (green), .blue (blue)
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;  // 10 ns period
    end

    function automatic int rand_in(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return lo + r % (hi - lo + 1);
    endfunction

    task automatic palette_lookup(input draw_pkg::cidx_t c, output draw_pkg::chan_t r,
                                  output draw_pkg::chan_t g, output draw_pkg::chan_t b);
        case (c)
            2'd1:    {r, g, b} = 12'hF80;   // orange
            2'd2:    {r, g, b} = 12'h0AA;   // teal
            2'd3:    {r, g, b} = 12'hFFF;   // white
            default: {r, g, b} = 12'h000;
        endcase
    endtask

    // reference Bresenham with clipped plot into the pending picture
    task automatic model_line(input int ax, input int ay, input int bx, input int by,
                              input draw_pkg::cidx_t c);
        int  px, py, dx, dy, stx, sty, err, e2;
        bit  fin;
        px  = ax;
        py  = ay;
        dx  = (bx > ax) ? bx - ax : ax - bx;
        dy  = (by > ay) ? ay - by : by - ay;   // negative or zero
        stx = (ax < bx) ? 1 : -1;
        sty = (ay < by) ? 1 : -1;
        err = dx + dy;
        fin = 0;
        while (!fin) begin
            if (px >= 0 && px < `FB_WIDTH && py >= 0 && py < `FB_HEIGHT)
                pending[px][py] = c;
            if (px == bx && py == by) begin
                fin = 1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    px  += stx;
                end
                if (e2 <= dx) begin
                    err += dx;
                    py  += sty;
                end
            end
        end
    endtask

    task automatic check_rgb(input draw_pkg::chan_t er, input draw_pkg::chan_t eg,
                             input draw_pkg::chan_t eb);
        if (red !== er || green !== eg || blue !== eb) begin
            rgb_errs++;
            $display("Fail %0t: rgb at %0d,%0d got %h%h%h exp %h%h%h", $time,
                     msx, msy, red, green, blue, er, eg, eb);
        end
    endtask

    task automatic check_sync(input logic eh, input logic ev, input logic ede);
        if (hsync !== eh || vsync !== ev || de !== ede) begin
            sync_errs++;
            $display("Fail %0t: sync at %0d,%0d got h%b v%b de%b exp h%b v%b de%b",
                     $time, msx, msy, hsync, vsync, de, eh, ev, ede);
        end
    endtask

    task automatic check_busy(input logic eb);
        if (busy !== eb) begin
            busy_errs++;
            $display("Fail %0t: busy got %b exp %b", $time, busy, eb);
        end
    endtask

    // one req pulse driven just after the clock edge
    task automatic issue_req(input int ax, input int ay, input int bx, input int by,
                             input draw_pkg::cidx_t c);
        @(posedge clk_pix);
        #1;
        x0   = draw_pkg::coord_t'(ax);
        y0   = draw_pkg::coord_t'(ay);
        x1   = draw_pkg::coord_t'(bx);
        y1   = draw_pkg::coord_t'(by);
        cidx = c;
        req  = 1'b1;
        @(posedge clk_pix);
        #1;
        req  = 1'b0;
    endtask

    // gives up after one frame
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy === 1'b1 && n < FRAME_CYCLES) begin
            @(posedge clk_pix);
            #1;
            n++;
        end
    endtask

    // raster and picture monitor sampled mid cycle
    always @(negedge clk_pix) begin
        draw_pkg::chan_t er, eg, eb;
        logic            ede;
        if (!synced && rst_n) begin
            if (vsync_prev && !vsync) begin     // first vsync edge is line 490
                synced = 1;
                msx    = 0;
                msy    = `V_FP_END;
            end
            vsync_prev = vsync;
        end
        if (synced) begin
            if (msx == 0 && msy == 0) begin     // new frame shows all lines so far
                for (int i = 0; i < `FB_WIDTH; i++)
                    for (int j = 0; j < `FB_HEIGHT; j++)
                        shown[i][j] = pending[i][j];
                frame_count++;
            end
            ede = (msx < `H_RES) && (msy < `V_RES);
            check_sync(!(msx >= `H_FP_END && msx < `H_SYNC_END),
                       !(msy >= `V_FP_END && msy < `V_SYNC_END), ede);
            if (ede)
                palette_lookup(shown[msx / `FB_SCALE][msy / `FB_SCALE], er, eg, eb);
            else
                {er, eg, eb} = 12'h000;
            check_rgb(er, eg, eb);
            if (msx == `H_TOTAL - 1) begin
                msx = 0;
                msy = (msy == `V_TOTAL - 1) ? 0 : msy + 1;
            end else begin
                msx++;
            end
        end
    end

    always @(posedge clk_pix) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, frame %0d", cycles, frame_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int ax, ay, bx, by, fnum;
        draw_pkg::cidx_t c;
        seed  = 32'h9fa6df18;
        rst_n = 1'b0;
        req   = 1'b0;
        x0    = '0;
        y0    = '0;
        x1    = '0;
        y1    = '0;
        cidx  = '0;
        for (int i = 0; i < `FB_WIDTH; i++)
            for (int j = 0; j < `FB_HEIGHT; j++) begin
                pending[i][j] = '0;
                shown[i][j]   = '0;
            end
        repeat (16) @(posedge clk_pix);
        #1;
        rst_n = 1'b1;
        check_busy(1'b0);
        check_sync(1'b1, 1'b1, 1'b0);   // idle syncs right out of reset
        wait (frame_count >= 1);        // first checked frame stays black
        for (int k = 0; k < NUM_LINES; k++) begin
            fnum = frame_count;
            ax   = rand_in(-20, `FB_WIDTH + 19);
            ay   = rand_in(-20, `FB_HEIGHT + 19);
            bx   = rand_in(-20, `FB_WIDTH + 19);
            by   = rand_in(-20, `FB_HEIGHT + 19);
            c    = draw_pkg::cidx_t'(rand_in(0, 3));
            model_line(ax, ay, bx, by, c);
            issue_req(ax, ay, bx, by, c);
            check_busy(1'b1);
            if (k % 4 == 1) begin       // extra req while armed must vanish
                issue_req(rand_in(0, 159), rand_in(0, 119), rand_in(0, 159),
                          rand_in(0, 119), draw_pkg::cidx_t'(rand_in(1, 3)));
                check_busy(1'b1);
            end
            wait_idle();
            check_busy(1'b0);
            wait (frame_count > fnum);  // this frame carries the new line
        end
        fnum = frame_count;
        wait (frame_count > fnum);      // last picture scanned in full
        $display("errors: rgb %0d sync %0d busy %0d", rgb_errs, sync_errs, busy_errs);
        if (rgb_errs + sync_errs + busy_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* logic/line_display_top.sv */
// line drawing display top
// timing, draw sequencer, line engine and framebuffer on one pixel clock

`timescale 1ns/1ps

module line_display_top (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  logic             req,
    input  draw_pkg::coord_t x0,
    input  draw_pkg::coord_t y0,
    input  draw_pkg::coord_t x1,
    input  draw_pkg::coord_t y1,
    input  draw_pkg::cidx_t  cidx,
    output logic             busy,
    output logic             hsync,
    output logic             vsync,
    output logic             de,
    output draw_pkg::chan_t  red,
    output draw_pkg::chan_t  green,
    output draw_pkg::chan_t  blue
);

    disp_pkg::scr_pos_t sx, sy;
    logic               t_hsync, t_vsync, t_de;     // undelayed timing
    logic               frame;

    logic               start, drawing, done;
    draw_pkg::coord_t   lx0, ly0, lx1, ly1;
    draw_pkg::coord_t   px, py;                     // engine output point
    draw_pkg::cidx_t    draw_cidx;

    display_timing i_display_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (t_hsync),
        .vsync   (t_vsync),
        .de      (t_de),
        .frame   (frame),
        .line    ()             // per line pulse not needed here
    );

    draw_sequencer i_draw_sequencer (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .req       (req),
        .x0        (x0),
        .y0        (y0),
        .x1        (x1),
        .y1        (y1),
        .cidx      (cidx),
        .frame     (frame),
        .done      (done),
        .start     (start),
        .lx0       (lx0),
        .ly0       (ly0),
        .lx1       (lx1),
        .ly1       (ly1),
        .draw_cidx (draw_cidx),
        .busy      (busy)
    );

    line_engine i_line_engine (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .start   (start),
        .x0      (lx0),
        .y0      (ly0),
        .x1      (lx1),
        .y1      (ly1),
        .x       (px),
        .y       (py),
        .drawing (drawing),
        .done    (done)
    );

    framebuffer i_framebuffer (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .we      (drawing),     // every engine point is a write
        .x       (px),
        .y       (py),
        .cidx    (draw_cidx),
        .sx      (sx),
        .sy      (sy),
        .de      (t_de),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    // one cycle delay to line up with fb read data
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;  // syncs idle high
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            hsync <= t_hsync;
            vsync <= t_vsync;
            de    <= t_de;
        end
    end

endmodule

/* logic/framebuffer.sv */
// 160x120 2-bit pixel memory
// clipped write port, scaled registered readout and fixed palette

`timescale 1ns/1ps

`include "gfx_defines.svh"

module framebuffer (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic               we,
    input  draw_pkg::coord_t   x,
    input  draw_pkg::coord_t   y,
    input  draw_pkg::cidx_t    cidx,
    input  disp_pkg::scr_pos_t sx,
    input  disp_pkg::scr_pos_t sy,
    input  logic               de,
    output draw_pkg::chan_t    red,
    output draw_pkg::chan_t    green,
    output draw_pkg::chan_t    blue
);

    localparam int DEPTH = `FB_WIDTH * `FB_HEIGHT;
    localparam int ADDRW = $clog2(DEPTH);

    draw_pkg::cidx_t mem [DEPTH];

    logic               in_fb;
    logic [ADDRW-1:0]   waddr;
    disp_pkg::scr_pos_t fx, fy;
    logic [ADDRW-1:0]   raddr;
    draw_pkg::cidx_t    rd_cidx;
    logic               de_q;

    // blank picture at power up
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // write side, drop anything off the buffer
    assign in_fb = (x >= 0) && (x < `FB_WIDTH) && (y >= 0) && (y < `FB_HEIGHT);
    assign waddr = ADDRW'(32'(y) * `FB_WIDTH + 32'(x));     // row major

    always @(posedge clk_pix) begin
        if (we && in_fb) mem[waddr] <= cidx;
    end

    // read side, each fb pixel covers 4x4 display pixels
    assign fx    = sx / `FB_SCALE;
    assign fy    = sy / `FB_SCALE;
    assign raddr = ADDRW'(fy * `FB_WIDTH + fx);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            rd_cidx <= '0;
            de_q    <= 1'b0;
        end else begin
            if (de) rd_cidx <= mem[raddr];  // address only valid when active
            de_q <= de;                     // follows the read latency
        end
    end

    // palette, blanked outside the active area
    always_comb begin
        red   = '0;
        green = '0;
        blue  = '0;
        if (de_q) begin
            case (rd_cidx)
                2'd1: begin     // orange
                    red   = 4'hF;
                    green = 4'h8;
                end
                2'd2: begin     // teal
                    green = 4'hA;
                    blue  = 4'hA;
                end
                2'd3: begin     // white
                    red   = 4'hF;
                    green = 4'hF;
                    blue  = 4'hF;
                end
                default: ;      // black
            endcase
        end
    end

endmodule

/* logic/line_engine.sv */
// Bresenham line walker
// one framebuffer coordinate per cycle from (x0,y0) to (x1,y1)

`timescale 1ns/1ps

`include "gfx_defines.svh"

module line_engine (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  logic             start,
    input  draw_pkg::coord_t x0,
    input  draw_pkg::coord_t y0,
    input  draw_pkg::coord_t x1,
    input  draw_pkg::coord_t y1,
    output draw_pkg::coord_t x,
    output draw_pkg::coord_t y,
    output logic             drawing,
    output logic             done
);

    localparam int DW = `CORDW + 1;     // delta width, one extra for the difference
    localparam int EW = `CORDW + 2;     // error term width

    typedef enum logic [1:0] {
        S_IDLE,
        S_INIT,     // first point out
        S_WALK
    } eng_state_t;

    eng_state_t state;

    logic signed [DW-1:0] diff_x, diff_y;
    logic signed [DW-1:0] abs_dx, abs_dy;
    logic signed [DW-1:0] dx, dy;           // dy held negative
    logic signed [EW-1:0] err, err_nxt;
    logic signed [EW:0]   e2;
    draw_pkg::coord_t     xs, ys;           // +1 or -1
    draw_pkg::coord_t     xe, ye;           // end point
    logic                 step_x, step_y;
    logic                 at_end;

    // deltas straight from the inputs, used on start
    assign diff_x = DW'(x1) - DW'(x0);
    assign diff_y = DW'(y1) - DW'(y0);
    assign abs_dx = diff_x[DW-1] ? -diff_x : diff_x;
    assign abs_dy = diff_y[DW-1] ? -diff_y : diff_y;

    // step decision on current error
    assign e2      = {err, 1'b0};
    assign step_x  = (e2 >= dy);
    assign step_y  = (e2 <= dx);
    assign err_nxt = err + (step_x ? EW'(dy) : '0) + (step_y ? EW'(dx) : '0);

    assign at_end  = (x == xe) && (y == ye);
    assign drawing = (state != S_IDLE);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            done  <= 1'b0;
            x     <= '0;
            y     <= '0;
            xe    <= '0;
            ye    <= '0;
            xs    <= '0;
            ys    <= '0;
            dx    <= '0;
            dy    <= '0;
            err   <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        x     <= x0;
                        y     <= y0;
                        xe    <= x1;
                        ye    <= y1;
                        xs    <= diff_x[DW-1] ? -1 : 1;
                        ys    <= diff_y[DW-1] ? -1 : 1;
                        dx    <= abs_dx;
                        dy    <= -abs_dy;
                        err   <= EW'(abs_dx) - EW'(abs_dy);    // dx + dy
                        state <= S_INIT;
                    end
                end
                default: begin  // S_INIT and S_WALK both emit a point
                    if (at_end) begin
                        done  <= 1'b1;  // cycle after last point
                        state <= S_IDLE;
                    end else begin
                        if (step_x) x <= x + xs;
                        if (step_y) y <= y + ys;
                        err   <= err_nxt;
                        state <= S_WALK;
                    end
                end
            endcase
        end
    end

endmodule

/* logic/draw_sequencer.sv */
// draw sequencer FSM
// captures one line request and runs it at the next frame pulse

`timescale 1ns/1ps

module draw_sequencer (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  logic             req,
    input  draw_pkg::coord_t x0,
    input  draw_pkg::coord_t y0,
    input  draw_pkg::coord_t x1,
    input  draw_pkg::coord_t y1,
    input  draw_pkg::cidx_t  cidx,
    input  logic             frame,
    input  logic             done,
    output logic             start,
    output draw_pkg::coord_t lx0,
    output draw_pkg::coord_t ly0,
    output draw_pkg::coord_t lx1,
    output draw_pkg::coord_t ly1,
    output draw_pkg::cidx_t  draw_cidx,
    output logic             busy
);

    draw_pkg::draw_state_t state;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state     <= draw_pkg::IDLE;
            start     <= 1'b0;
            lx0       <= '0;
            ly0       <= '0;
            lx1       <= '0;
            ly1       <= '0;
            draw_cidx <= '0;
        end else begin
            start <= 1'b0;  // single cycle pulse
            case (state)
                draw_pkg::IDLE: begin
                    if (req) begin  // only place a request is taken
                        lx0       <= x0;
                        ly0       <= y0;
                        lx1       <= x1;
                        ly1       <= y1;
                        draw_cidx <= cidx;
                        state     <= draw_pkg::ARMED;
                    end
                end
                draw_pkg::ARMED: begin
                    if (frame) begin    // wait for vertical blanking
                        start <= 1'b1;
                        state <= draw_pkg::DRAW;
                    end
                end
                draw_pkg::DRAW: if (done) state <= draw_pkg::DONE;
                default:        state <= draw_pkg::IDLE;   // DONE
            endcase
        end
    end

    // req while busy simply falls through the FSM
    assign busy = (state != draw_pkg::IDLE);

endmodule

/* logic/display_timing.sv */
// 480p raster counters
// syncs, data enable, frame and line pulses decoded from the counters

`timescale 1ns/1ps

`include "gfx_defines.svh"

module display_timing (
    input  logic              clk_pix,
    input  logic              rst_n,
    output disp_pkg::scr_pos_t sx,      // horizontal position
    output disp_pkg::scr_pos_t sy,      // vertical position
    output logic              hsync,    // active low
    output logic              vsync,    // active low
    output logic              de,       // active area
    output logic              frame,    // start of vertical blanking
    output logic              line      // start of every line
);

    logic line_end;
    logic frame_end;

    assign line_end  = (sx == disp_pkg::scr_pos_t'(`H_TOTAL - 1));
    assign frame_end = (sy == disp_pkg::scr_pos_t'(`V_TOTAL - 1));

    // free running counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (line_end) begin
                sx <= '0;
                sy <= frame_end ? '0 : sy + 1'b1;   // wrap at V_TOTAL
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // sync windows, both polarities negative for 480p
    assign hsync = !(sx >= `H_FP_END && sx < `H_SYNC_END);
    assign vsync = !(sy >= `V_FP_END && sy < `V_SYNC_END);

    assign de = (sx < `H_RES) && (sy < `V_RES);

    // frame pulse lands at first blanking line so drawing never tears
    assign frame = (sx == '0) && (sy == disp_pkg::scr_pos_t'(`V_RES));
    assign line  = (sx == '0);

endmodule

/* logic/draw_pkg.sv */
// drawing side types
// framebuffer coordinates, colour index and channel, sequencer states

`include "gfx_defines.svh"

package draw_pkg;

    // signed so lines may start or end off the framebuffer
    typedef logic signed [`CORDW-1:0] coord_t;

    typedef logic [1:0] cidx_t;     // palette index, 4 colours
    typedef logic [3:0] chan_t;     // one RGB channel

    // draw sequencer FSM
    typedef enum logic [1:0] {
        IDLE,   // waiting for req
        ARMED,  // request held, waiting for frame
        DRAW,   // engine running
        DONE    // one cycle before returning to idle
    } draw_state_t;

endpackage

/* logic/disp_pkg.sv */
// display side types
// screen position as produced by the timing counters

`include "gfx_defines.svh"

package disp_pkg;

    // counter position, wide enough for the full 800x525 raster
    typedef logic [$clog2(`H_TOTAL)-1:0] scr_pos_t;

endpackage

/* logic/gfx_defines.svh */
// display timing, framebuffer geometry and coordinate width macros
// 640x480 at 60 Hz with a 160x120 framebuffer scaled by 4

`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// horizontal timing in pixels
`define H_RES       640
`define H_FP_END    656     // end of front porch, sync starts
`define H_SYNC_END  752     // sync ends, back porch starts
`define H_TOTAL     800

// vertical timing in lines
`define V_RES       480
`define V_FP_END    490
`define V_SYNC_END  492
`define V_TOTAL     525

// framebuffer
`define FB_WIDTH    160
`define FB_HEIGHT   120
`define FB_SCALE    4       // display pixels per fb pixel, each axis

`define CORDW       16      // signed drawing coordinate width

`endif
